// File: Makefile
VERILATOR ?= verilator
TOP       ?= cache_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= Simulation passed

.PHONY: sim clean

# Build, run, and pass only if the pass line appears in the output
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: project.f
rtl/cache_cfg_pkg.sv
rtl/cache_bus_pkg.sv
rtl/cache_tag_array.sv
rtl/cache_data_array.sv
rtl/cache_ctrl.sv
rtl/cache_top.sv
verif/tb_clock.sv
verif/mem_model.sv
verif/cache_tb.sv

// File: rtl/cache_bus_pkg.sv
package cache_bus_pkg;

    // Core request, one 32-bit word
    typedef struct packed {
        logic        we;
        logic [3:0]  be;
        logic [31:0] addr;
        logic [31:0] wdata;
    } core_req_t;

    // Memory bus packet
    // Write-back beats carry data, a fill request only its block address
    typedef struct packed {
        logic                 we;
        logic [31:0]          addr;
        cache_cfg_pkg::beat_t wdata;
    } mem_req_t;

endpackage

// File: rtl/cache_cfg_pkg.sv
package cache_cfg_pkg;

    // Cache geometry
    localparam int NUM_SETS        = 8;
    localparam int NUM_WAYS        = 2;
    localparam int BLOCK_WORDS     = 4;
    localparam int BEAT_WORDS      = 2;
    localparam int BEATS_PER_BLOCK = BLOCK_WORDS / BEAT_WORDS;

    // Address split: tag | index | byte offset
    localparam int OFFSET_W = $clog2(BLOCK_WORDS) + 2;
    localparam int INDEX_W  = $clog2(NUM_SETS);
    localparam int TAG_W    = 32 - OFFSET_W - INDEX_W;

    typedef logic [TAG_W-1:0]                   tag_t;
    typedef logic [INDEX_W-1:0]                 set_idx_t;
    typedef logic [$clog2(NUM_WAYS)-1:0]        way_idx_t;
    typedef logic [$clog2(BLOCK_WORDS)-1:0]     word_idx_t;
    typedef logic [$clog2(BEATS_PER_BLOCK)-1:0] beat_idx_t;

    // One bus beat, word 0 in the low bits
    typedef logic [BEAT_WORDS*32-1:0] beat_t;

    typedef enum logic [1:0] {
        LINE_INVALID = 2'b00,
        LINE_CLEAN   = 2'b01,
        LINE_DIRTY   = 2'b10
    } line_state_e;

endpackage

// File: rtl/cache_ctrl.sv
module cache_ctrl (
    input  logic                      clk_i,
    input  logic                      nreset_i,

    // Core port
    input  logic                      core_valid_i,
    output logic                      core_ready_o,
    input  cache_bus_pkg::core_req_t  core_req_i,
    output logic                      core_resp_valid_o,
    output logic [31:0]               core_rdata_o,

    // Memory port
    output logic                      mem_valid_o,
    input  logic                      mem_ready_i,
    output cache_bus_pkg::mem_req_t   mem_req_o,
    input  logic                      mem_rvalid_i,

    // Tag array
    output cache_cfg_pkg::set_idx_t   lookup_set_o,
    output cache_cfg_pkg::tag_t       lookup_tag_o,
    output logic                      touch_o,
    output cache_cfg_pkg::way_idx_t   touch_way_o,
    output logic                      tag_fill_o,
    output cache_cfg_pkg::way_idx_t   fill_way_o,
    output logic                      fill_dirty_o,
    output logic                      mark_dirty_o,
    output cache_cfg_pkg::way_idx_t   mark_way_o,
    input  logic                      hit_i,
    input  cache_cfg_pkg::way_idx_t   hit_way_i,
    input  cache_cfg_pkg::way_idx_t   victim_way_i,
    input  logic                      victim_dirty_i,
    input  cache_cfg_pkg::tag_t       victim_tag_i,

    // Data array
    output cache_cfg_pkg::way_idx_t   data_way_o,
    output cache_cfg_pkg::word_idx_t  data_word_o,
    output cache_cfg_pkg::beat_idx_t  data_beat_o,
    output logic                      data_store_o,
    output logic [3:0]                data_be_o,
    output logic [31:0]               data_wdata_o,
    output logic                      data_fill_o,
    input  logic [31:0]               rd_word_i,
    input  cache_cfg_pkg::beat_t      rd_beat_i
);

    localparam cache_cfg_pkg::beat_idx_t LAST_BEAT =
        cache_cfg_pkg::beat_idx_t'(cache_cfg_pkg::BEATS_PER_BLOCK - 1);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_WB,
        ST_FILL_REQ,
        ST_FILL
    } state_e;

    state_e                    state_q, state_d;
    cache_bus_pkg::core_req_t  req_q;
    cache_cfg_pkg::beat_idx_t  wb_cnt_q, fill_cnt_q;
    logic                      accept, lookup_hit, wb_fire, fill_beat;

    assign accept     = core_valid_i & core_ready_o;
    assign lookup_hit = (state_q == ST_LOOKUP) & hit_i;
    assign wb_fire    = (state_q == ST_WB) & mem_ready_i;
    assign fill_beat  = (state_q == ST_FILL) & mem_rvalid_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:     if (accept) state_d = ST_LOOKUP;
            ST_LOOKUP:   state_d = hit_i ? ST_IDLE : (victim_dirty_i ? ST_WB : ST_FILL_REQ);
            ST_WB:       if (wb_fire && wb_cnt_q == LAST_BEAT) state_d = ST_FILL_REQ;
            ST_FILL_REQ: if (mem_ready_i) state_d = ST_FILL;
            // Second lookup after the last beat now hits
            ST_FILL:     if (fill_beat && fill_cnt_q == LAST_BEAT) state_d = ST_LOOKUP;
            default:     state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (nreset_i) begin
            state_q    <= ST_IDLE;
            wb_cnt_q   <= '0;
            fill_cnt_q <= '0;
        end else begin
            state_q <= state_d;
            if (wb_fire) begin
                wb_cnt_q <= wb_cnt_q + 1'b1;
            end
            if (fill_beat) begin
                fill_cnt_q <= fill_cnt_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            req_q <= core_req_i;
        end
    end

    assign core_ready_o      = state_q == ST_IDLE;
    assign core_resp_valid_o = lookup_hit;
    assign core_rdata_o      = req_q.we ? '0 : rd_word_i;

    assign lookup_set_o = req_q.addr[cache_cfg_pkg::OFFSET_W +: cache_cfg_pkg::INDEX_W];
    assign lookup_tag_o = req_q.addr[31 -: cache_cfg_pkg::TAG_W];

    assign touch_o      = lookup_hit;
    assign touch_way_o  = hit_way_i;
    assign mark_dirty_o = lookup_hit & req_q.we;
    assign mark_way_o   = hit_way_i;

    // Tag and state go live with the last fill beat
    assign tag_fill_o   = fill_beat & (fill_cnt_q == LAST_BEAT);
    assign fill_way_o   = victim_way_i;
    assign fill_dirty_o = req_q.we;

    // Victim way stays put until the tag fill
    assign data_way_o   = (state_q == ST_LOOKUP) ? hit_way_i : victim_way_i;
    assign data_word_o  = req_q.addr[cache_cfg_pkg::OFFSET_W-1:2];
    assign data_beat_o  = (state_q == ST_FILL) ? fill_cnt_q : wb_cnt_q;
    assign data_store_o = lookup_hit & req_q.we;
    assign data_be_o    = req_q.be;
    assign data_wdata_o = req_q.wdata;
    assign data_fill_o  = fill_beat;

    assign mem_valid_o = (state_q == ST_WB) | (state_q == ST_FILL_REQ);

    always_comb begin
        mem_req_o.we = state_q == ST_WB;
        if (state_q == ST_WB) begin
            mem_req_o.addr  = {victim_tag_i, lookup_set_o, wb_cnt_q,
                               {(cache_cfg_pkg::OFFSET_W - $bits(wb_cnt_q)){1'b0}}};
            mem_req_o.wdata = rd_beat_i;
        end else begin
            mem_req_o.addr  = {req_q.addr[31:cache_cfg_pkg::OFFSET_W],
                               {cache_cfg_pkg::OFFSET_W{1'b0}}};
            mem_req_o.wdata = '0;
        end
    end

    a_rvalid_in_fill: assert property (@(posedge clk_i) disable iff (nreset_i)
        mem_rvalid_i |-> state_q == ST_FILL)
        else $error("read beat outside fill state");

    // The lookup right after the tag fill must hit
    a_refill_hit: assert property (@(posedge clk_i) disable iff (nreset_i)
        tag_fill_o |=> hit_i)
        else $error("second lookup after fill missed");

    a_be_contiguous: assert property (@(posedge clk_i) disable iff (nreset_i)
        accept & core_req_i.we |-> core_req_i.be inside {4'b0000, 4'b0001, 4'b0010,
            4'b0100, 4'b1000, 4'b0011, 4'b0110, 4'b1100, 4'b0111, 4'b1110, 4'b1111})
        else $error("non-contiguous byte enables %b", core_req_i.be);

endmodule

// File: rtl/cache_data_array.sv
module cache_data_array (
    input  logic                     clk_i,

    // Addressing
    input  cache_cfg_pkg::set_idx_t  set_i,
    input  cache_cfg_pkg::way_idx_t  way_i,
    input  cache_cfg_pkg::word_idx_t word_i,
    input  cache_cfg_pkg::beat_idx_t beat_i,

    // Byte-enabled store of one word
    input  logic                     store_i,
    input  logic [3:0]               store_be_i,
    input  logic [31:0]              store_data_i,

    // Fill of one beat
    input  logic                     fill_i,
    input  cache_cfg_pkg::beat_t     fill_data_i,

    output logic [31:0]              rd_word_o,
    output cache_cfg_pkg::beat_t     rd_beat_o
);

    logic [31:0] word_q [cache_cfg_pkg::NUM_SETS]
                        [cache_cfg_pkg::NUM_WAYS]
                        [cache_cfg_pkg::BLOCK_WORDS];

    // Word position of word i within the addressed beat
    function automatic cache_cfg_pkg::word_idx_t beat_word(
        input cache_cfg_pkg::beat_idx_t beat,
        input int                       i
    );
        beat_word = cache_cfg_pkg::word_idx_t'(int'(beat) * cache_cfg_pkg::BEAT_WORDS + i);
    endfunction

    assign rd_word_o = word_q[set_i][way_i][word_i];

    // Beat read for write-back
    always_comb begin
        for (int i = 0; i < cache_cfg_pkg::BEAT_WORDS; i++) begin
            rd_beat_o[i*32 +: 32] = word_q[set_i][way_i][beat_word(beat_i, i)];
        end
    end

    always_ff @(posedge clk_i) begin
        if (fill_i) begin
            for (int i = 0; i < cache_cfg_pkg::BEAT_WORDS; i++) begin
                word_q[set_i][way_i][beat_word(beat_i, i)] <= fill_data_i[i*32 +: 32];
            end
        end else if (store_i) begin
            // Merge only the enabled bytes
            for (int b = 0; b < 4; b++) begin
                if (store_be_i[b]) begin
                    word_q[set_i][way_i][word_i][b*8 +: 8] <= store_data_i[b*8 +: 8];
                end
            end
        end
    end

endmodule

// File: rtl/cache_tag_array.sv
module cache_tag_array (
    input  logic                    clk_i,
    input  logic                    nreset_i,

    // Lookup
    input  cache_cfg_pkg::set_idx_t lookup_set_i,
    input  cache_cfg_pkg::tag_t     lookup_tag_i,

    // Updates, all applied to the lookup set
    input  logic                    touch_i,
    input  cache_cfg_pkg::way_idx_t touch_way_i,
    input  logic                    fill_i,
    input  cache_cfg_pkg::way_idx_t fill_way_i,
    input  logic                    fill_dirty_i,
    input  logic                    mark_dirty_i,
    input  cache_cfg_pkg::way_idx_t mark_way_i,

    // Lookup results
    output logic                    hit_o,
    output cache_cfg_pkg::way_idx_t hit_way_o,
    output cache_cfg_pkg::way_idx_t victim_way_o,
    output logic                    victim_dirty_o,
    output cache_cfg_pkg::tag_t     victim_tag_o
);

    cache_cfg_pkg::tag_t        tag_q   [cache_cfg_pkg::NUM_SETS][cache_cfg_pkg::NUM_WAYS];
    cache_cfg_pkg::line_state_e state_q [cache_cfg_pkg::NUM_SETS][cache_cfg_pkg::NUM_WAYS];

    // One bit per set naming the way to replace next
    logic [cache_cfg_pkg::NUM_SETS-1:0] plru_q;

    logic [cache_cfg_pkg::NUM_WAYS-1:0] way_hit;

    always_comb begin
        hit_way_o = '0;
        for (int w = 0; w < cache_cfg_pkg::NUM_WAYS; w++) begin
            way_hit[w] = (state_q[lookup_set_i][w] != cache_cfg_pkg::LINE_INVALID) &&
                         (tag_q[lookup_set_i][w] == lookup_tag_i);
            if (way_hit[w]) begin
                hit_way_o = cache_cfg_pkg::way_idx_t'(w);
            end
        end
        hit_o = |way_hit;
    end

    // Lowest invalid way wins, else the pLRU way
    always_comb begin
        victim_way_o = plru_q[lookup_set_i];
        for (int w = cache_cfg_pkg::NUM_WAYS - 1; w >= 0; w--) begin
            if (state_q[lookup_set_i][w] == cache_cfg_pkg::LINE_INVALID) begin
                victim_way_o = cache_cfg_pkg::way_idx_t'(w);
            end
        end
    end

    assign victim_dirty_o = state_q[lookup_set_i][victim_way_o] == cache_cfg_pkg::LINE_DIRTY;
    assign victim_tag_o   = tag_q[lookup_set_i][victim_way_o];

    always_ff @(posedge clk_i) begin
        if (nreset_i) begin
            for (int s = 0; s < cache_cfg_pkg::NUM_SETS; s++) begin
                for (int w = 0; w < cache_cfg_pkg::NUM_WAYS; w++) begin
                    state_q[s][w] <= cache_cfg_pkg::LINE_INVALID;
                end
            end
            plru_q <= '0;
        end else begin
            if (touch_i) begin
                plru_q[lookup_set_i] <= ~touch_way_i;
            end
            if (fill_i) begin
                state_q[lookup_set_i][fill_way_i] <= fill_dirty_i ? cache_cfg_pkg::LINE_DIRTY
                                                                  : cache_cfg_pkg::LINE_CLEAN;
            end
            if (mark_dirty_i) begin
                state_q[lookup_set_i][mark_way_i] <= cache_cfg_pkg::LINE_DIRTY;
            end
        end
    end

    // Tags only matter once the line is valid
    always_ff @(posedge clk_i) begin
        if (fill_i) begin
            tag_q[lookup_set_i][fill_way_i] <= lookup_tag_i;
        end
    end

    // A fill never installs a tag that is already valid elsewhere in the set
    a_hit_onehot: assert property (@(posedge clk_i) disable iff (nreset_i)
        $onehot0(way_hit))
        else $error("two ways hit in set %0d", lookup_set_i);

endmodule

// File: rtl/cache_top.sv
module cache_top (
    input  logic                     clk_i,
    input  logic                     nreset_i,

    input  logic                     core_valid_i,
    output logic                     core_ready_o,
    input  cache_bus_pkg::core_req_t core_req_i,
    output logic                     core_resp_valid_o,
    output logic [31:0]              core_rdata_o,

    output logic                     mem_valid_o,
    input  logic                     mem_ready_i,
    output cache_bus_pkg::mem_req_t  mem_req_o,
    input  logic                     mem_rvalid_i,
    input  cache_cfg_pkg::beat_t     mem_rdata_i
);

    // Controller to tag array
    cache_cfg_pkg::set_idx_t  lookup_set;
    cache_cfg_pkg::tag_t      lookup_tag;
    logic                     touch, tag_fill, fill_dirty, mark_dirty;
    cache_cfg_pkg::way_idx_t  touch_way, fill_way, mark_way;

    // Tag array results
    logic                     hit, victim_dirty;
    cache_cfg_pkg::way_idx_t  hit_way, victim_way;
    cache_cfg_pkg::tag_t      victim_tag;

    // Controller to data array
    cache_cfg_pkg::way_idx_t  data_way;
    cache_cfg_pkg::word_idx_t data_word;
    cache_cfg_pkg::beat_idx_t data_beat;
    logic                     data_store, data_fill;
    logic [3:0]               data_be;
    logic [31:0]              data_wdata, rd_word;
    cache_cfg_pkg::beat_t     rd_beat;

    cache_ctrl u_ctrl (
        .clk_i             (clk_i),
        .nreset_i          (nreset_i),
        .core_valid_i      (core_valid_i),
        .core_ready_o      (core_ready_o),
        .core_req_i        (core_req_i),
        .core_resp_valid_o (core_resp_valid_o),
        .core_rdata_o      (core_rdata_o),
        .mem_valid_o       (mem_valid_o),
        .mem_ready_i       (mem_ready_i),
        .mem_req_o         (mem_req_o),
        .mem_rvalid_i      (mem_rvalid_i),
        .lookup_set_o      (lookup_set),
        .lookup_tag_o      (lookup_tag),
        .touch_o           (touch),
        .touch_way_o       (touch_way),
        .tag_fill_o        (tag_fill),
        .fill_way_o        (fill_way),
        .fill_dirty_o      (fill_dirty),
        .mark_dirty_o      (mark_dirty),
        .mark_way_o        (mark_way),
        .hit_i             (hit),
        .hit_way_i         (hit_way),
        .victim_way_i      (victim_way),
        .victim_dirty_i    (victim_dirty),
        .victim_tag_i      (victim_tag),
        .data_way_o        (data_way),
        .data_word_o       (data_word),
        .data_beat_o       (data_beat),
        .data_store_o      (data_store),
        .data_be_o         (data_be),
        .data_wdata_o      (data_wdata),
        .data_fill_o       (data_fill),
        .rd_word_i         (rd_word),
        .rd_beat_i         (rd_beat)
    );

    cache_tag_array u_tags (
        .clk_i          (clk_i),
        .nreset_i       (nreset_i),
        .lookup_set_i   (lookup_set),
        .lookup_tag_i   (lookup_tag),
        .touch_i        (touch),
        .touch_way_i    (touch_way),
        .fill_i         (tag_fill),
        .fill_way_i     (fill_way),
        .fill_dirty_i   (fill_dirty),
        .mark_dirty_i   (mark_dirty),
        .mark_way_i     (mark_way),
        .hit_o          (hit),
        .hit_way_o      (hit_way),
        .victim_way_o   (victim_way),
        .victim_dirty_o (victim_dirty),
        .victim_tag_o   (victim_tag)
    );

    // Set index is shared with the tag lookup
    cache_data_array u_data (
        .clk_i        (clk_i),
        .set_i        (lookup_set),
        .way_i        (data_way),
        .word_i       (data_word),
        .beat_i       (data_beat),
        .store_i      (data_store),
        .store_be_i   (data_be),
        .store_data_i (data_wdata),
        .fill_i       (data_fill),
        .fill_data_i  (mem_rdata_i),
        .rd_word_o    (rd_word),
        .rd_beat_o    (rd_beat)
    );

endmodule

// File: verif/cache_tb.sv
module cache_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned SEED          = 32'h0a62_cce7;
    localparam logic [31:0] PATTERN       = 32'h5a5a_0000;
    localparam int          CLK_PERIOD_NS = 100;

    // 21 requests over all tests, and a generous bound on one miss
    localparam int NUM_REQUESTS      = 21;
    localparam int WORST_MISS_CYCLES = 24;
    localparam int TIMEOUT_NS = 40 * NUM_REQUESTS * WORST_MISS_CYCLES * CLK_PERIOD_NS;

    logic                     clk;
    logic                     nreset;
    logic                     core_valid;
    logic                     core_ready;
    cache_bus_pkg::core_req_t core_req;
    logic                     core_resp_valid;
    logic [31:0]              core_rdata;
    logic                     mem_valid;
    logic                     mem_ready;
    cache_bus_pkg::mem_req_t  mem_req;
    logic                     mem_rvalid;
    cache_cfg_pkg::beat_t     mem_rdata;

    // Expected contents of every word the core has written
    logic [31:0] ref_q [logic [29:0]];

    tb_clock #(.PERIOD_NS(CLK_PERIOD_NS)) u_clock (.clk_o(clk));

    cache_top u_dut (
        .clk_i             (clk),
        .nreset_i          (nreset),
        .core_valid_i      (core_valid),
        .core_ready_o      (core_ready),
        .core_req_i        (core_req),
        .core_resp_valid_o (core_resp_valid),
        .core_rdata_o      (core_rdata),
        .mem_valid_o       (mem_valid),
        .mem_ready_i       (mem_ready),
        .mem_req_o         (mem_req),
        .mem_rvalid_i      (mem_rvalid),
        .mem_rdata_i       (mem_rdata)
    );

    mem_model #(.SEED(SEED)) u_mem (
        .clk_i        (clk),
        .nreset_i     (nreset),
        .mem_valid_i  (mem_valid),
        .mem_ready_o  (mem_ready),
        .mem_req_i    (mem_req),
        .mem_rvalid_o (mem_rvalid),
        .mem_rdata_o  (mem_rdata)
    );

    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        if (ref_q.exists(addr[31:2])) begin
            return ref_q[addr[31:2]];
        end
        return {addr[31:2], 2'b00} ^ PATTERN;
    endfunction

    task automatic check_equal(
        input string       name,
        input logic [31:0] actual,
        input logic [31:0] expected
    );
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // Called on a falling edge, returns on the falling edge that shows the response
    task automatic issue_request(
        input  logic        we,
        input  logic [3:0]  be,
        input  logic [31:0] addr,
        input  logic [31:0] wdata,
        output logic [31:0] rdata,
        output int          cycles
    );
        while (!core_ready) begin
            @(negedge clk);
        end
        core_valid     = 1'b1;
        core_req.we    = we;
        core_req.be    = be;
        core_req.addr  = addr;
        core_req.wdata = wdata;
        @(negedge clk);
        core_valid = 1'b0;
        cycles     = 1;
        while (!core_resp_valid) begin
            @(negedge clk);
            cycles++;
        end
        rdata = core_rdata;
    endtask

    task automatic read_check(input logic [31:0] addr, output int cycles);
        logic [31:0] rdata;
        issue_request(1'b0, 4'b0000, addr, '0, rdata, cycles);
        check_equal("core_rdata_o", rdata, expected_word(addr));
    endtask

    task automatic write_word(
        input  logic [31:0] addr,
        input  logic [3:0]  be,
        input  logic [31:0] data,
        output int          cycles
    );
        logic [31:0] merged;
        logic [31:0] rdata;
        merged = expected_word(addr);
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                merged[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        ref_q[addr[31:2]] = merged;
        issue_request(1'b1, be, addr, data, rdata, cycles);
        check_equal("core_rdata_o", rdata, 32'd0);
    endtask

    task automatic expect_hit(input int cycles);
        check_equal("core_resp_valid_o latency", cycles, 32'd1);
    endtask

    task automatic expect_miss(input int cycles);
        check_equal("core_resp_valid_o miss", (cycles > 1) ? 32'd1 : 32'd0, 32'd1);
    endtask

    task automatic test_reset_and_read_miss();
        int lat;
        check_equal("core_ready_o", 32'(core_ready), 32'd1);
        check_equal("mem_valid_o", 32'(mem_valid), 32'd0);
        read_check(32'h0000_1004, lat);
        expect_miss(lat);
        read_check(32'h0000_1004, lat);
        expect_hit(lat);
    endtask

    task automatic test_write_hit();
        int lat;
        write_word(32'h0000_1004, 4'b0110, 32'hdead_beef, lat);
        expect_hit(lat);
        read_check(32'h0000_1004, lat);
        expect_hit(lat);
    endtask

    // Whole block arrives with the write, so its other words hit
    task automatic test_write_miss();
        int lat;
        write_word(32'h0000_2018, 4'b1111, 32'h1234_5678, lat);
        expect_miss(lat);
        read_check(32'h0000_2010, lat);
        expect_hit(lat);
        read_check(32'h0000_2014, lat);
        expect_hit(lat);
        read_check(32'h0000_201c, lat);
        expect_hit(lat);
        read_check(32'h0000_2018, lat);
        expect_hit(lat);
    endtask

    // Three tags in set 2
    task automatic test_plru();
        int lat;
        read_check(32'h0000_3020, lat);
        expect_miss(lat);
        read_check(32'h0000_30a0, lat);
        expect_miss(lat);
        read_check(32'h0000_3020, lat);
        expect_hit(lat);
        // B is least recently used and goes
        read_check(32'h0000_3120, lat);
        expect_miss(lat);
        read_check(32'h0000_3020, lat);
        expect_hit(lat);
        read_check(32'h0000_30a0, lat);
        expect_miss(lat);
    endtask

    // Dirty words in both beats of a block in set 3
    task automatic test_dirty_eviction();
        int lat;
        write_word(32'h0000_4030, 4'b1100, 32'hcafe_0000, lat);
        expect_miss(lat);
        write_word(32'h0000_403c, 4'b0011, 32'h0000_f00d, lat);
        expect_hit(lat);
        read_check(32'h0000_40b0, lat);
        expect_miss(lat);
        read_check(32'h0000_4130, lat);
        expect_miss(lat);
        // Data now comes back from memory
        read_check(32'h0000_4030, lat);
        expect_miss(lat);
        read_check(32'h0000_403c, lat);
        expect_hit(lat);
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: no result after %0d ns, a request never completed", TIMEOUT_NS);
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        core_valid = 1'b0;
        core_req   = '0;
        nreset     = 1'b1;
        repeat (5) @(negedge clk);
        nreset = 1'b0;

        test_reset_and_read_miss();
        test_write_hit();
        test_write_miss();
        test_plru();
        test_dirty_eviction();

        $display("Simulation passed");
        $finish;
    end

endmodule

// File: verif/mem_model.sv
module mem_model #(
    parameter int unsigned SEED = 32'h0a62_cce7
) (
    input  logic                    clk_i,
    input  logic                    nreset_i,
    input  logic                    mem_valid_i,
    output logic                    mem_ready_o,
    input  cache_bus_pkg::mem_req_t mem_req_i,
    output logic                    mem_rvalid_o,
    output cache_cfg_pkg::beat_t    mem_rdata_o
);

    timeunit 1ns;
    timeprecision 1ps;

    // Words written back by the cache, keyed by word address
    logic [31:0] word_q [logic [29:0]];

    logic [31:0] fill_base;
    int          beats_left;
    int          beat_idx;

    // Untouched words hold their byte address XOR a fixed pattern
    function automatic logic [31:0] load_word(input logic [31:0] addr);
        if (word_q.exists(addr[31:2])) begin
            return word_q[addr[31:2]];
        end
        return {addr[31:2], 2'b00} ^ 32'h5a5a_0000;
    endfunction

    initial begin
        void'($urandom(SEED));
        mem_ready_o  = 1'b0;
        mem_rvalid_o = 1'b0;
        mem_rdata_o  = '0;
        fill_base    = '0;
        beats_left   = 0;
        beat_idx     = 0;
        forever begin
            @(negedge clk_i);
            // Ready set here holds through the next rising edge
            mem_ready_o = ($urandom % 4) != 0;

            // Pending fill beats go out in order, with random gaps
            if (beats_left > 0 && ($urandom % 3) != 0) begin
                for (int i = 0; i < cache_cfg_pkg::BEAT_WORDS; i++) begin
                    mem_rdata_o[i*32 +: 32] = load_word(fill_base +
                        32'(beat_idx * cache_cfg_pkg::BEAT_WORDS * 4 + i * 4));
                end
                mem_rvalid_o = 1'b1;
                beat_idx++;
                beats_left--;
            end else begin
                mem_rvalid_o = 1'b0;
            end

            // Valid and ready are both stable now, so this packet moves on the next edge
            if (!nreset_i && mem_valid_i && mem_ready_o) begin
                if (mem_req_i.we) begin
                    for (int i = 0; i < cache_cfg_pkg::BEAT_WORDS; i++) begin
                        word_q[mem_req_i.addr[31:2] + 30'(i)] = mem_req_i.wdata[i*32 +: 32];
                    end
                end else begin
                    fill_base  = mem_req_i.addr;
                    beats_left = cache_cfg_pkg::BEATS_PER_BLOCK;
                    beat_idx   = 0;
                end
            end
        end
    end

endmodule

// File: verif/tb_clock.sv
module tb_clock #(
    parameter int PERIOD_NS = 100
) (
    output logic clk_o
);

    timeunit 1ns;
    timeprecision 1ps;

    // Free-running clock, low for the first half period
    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

endmodule
